// ==== hdl/n64_video_pkg.sv ====
// n64 video front end package with bus widths, sync word fields and shared types

`default_nettype none

package n64_video_pkg;

  // ==========================================================================
  // widths
  // ==========================================================================

  // one colour sample as it appears on the N64 bus
  localparam int COLOR_IN_W  = 7;
  // one colour as sent to the video transmitter
  localparam int COLOR_OUT_W = 8;
  // sync word in VD bits 3 to 0
  localparam int SYNC_W      = 4;

  // lane 0 red, lane 1 green, lane 2 blue
  localparam int NUM_CHANNELS = 3;

  // ==========================================================================
  // sync word fields (all active low on the bus)
  // ==========================================================================

  localparam int SYNC_NVSYNC_BIT = 3;
  localparam int SYNC_NCLAMP_BIT = 2;
  localparam int SYNC_NHSYNC_BIT = 1;
  localparam int SYNC_NCSYNC_BIT = 0;

  // sample LSBs dropped in 16-bit colour mode
  localparam int LOW_BITS_16BIT = 2;

  // ==========================================================================
  // types
  // ==========================================================================

  typedef logic [COLOR_IN_W-1:0]  color_in_t;
  typedef logic [COLOR_OUT_W-1:0] color_out_t;
  typedef logic [SYNC_W-1:0]      sync_word_t;

  // word phase of the multiplexed bus
  typedef enum logic [1:0] {
    ST_WAIT_SYNC,
    ST_EXP_RED,
    ST_EXP_GREEN,
    ST_EXP_BLUE
  } demux_state_t;

endpackage

`default_nettype wire

// ==== hdl/n64_vdemux.sv ====
// n64 video demux that collects sync, red, green and blue words into one pixel

`timescale 1ns/1ps
`default_nettype none

module n64_vdemux (
  input  wire logic                      N64_CLK_i,
  input  wire logic                      rst_n_i,
  input  wire logic                      nVDSYNC_i,
  input  wire n64_video_pkg::color_in_t  VD_i,
  output logic                           pix_valid_o,
  input  wire logic                      pix_ready_i,
  output n64_video_pkg::sync_word_t      pix_sync_o,
  output n64_video_pkg::color_in_t       pix_red_o,
  output n64_video_pkg::color_in_t       pix_green_o,
  output n64_video_pkg::color_in_t       pix_blue_o,
  output logic                           overflow_o
);

  n64_video_pkg::demux_state_t state_q;

  // words of the pixel being collected
  n64_video_pkg::sync_word_t sync_q;
  n64_video_pkg::color_in_t  red_q;
  n64_video_pkg::color_in_t  green_q;

  logic pixel_done;
  logic pix_taken;

  assign pixel_done = nVDSYNC_i && (state_q == n64_video_pkg::ST_EXP_BLUE);
  assign pix_taken  = pix_valid_o && pix_ready_i;

  // ==========================================================================
  // word phase
  // ==========================================================================

  always_ff @(posedge N64_CLK_i) begin
    if (!rst_n_i) begin
      state_q <= n64_video_pkg::ST_WAIT_SYNC;
    end else if (!nVDSYNC_i) begin
      // a sync word always restarts the pixel
      state_q <= n64_video_pkg::ST_EXP_RED;
    end else begin
      case (state_q)
        n64_video_pkg::ST_EXP_RED:   state_q <= n64_video_pkg::ST_EXP_GREEN;
        n64_video_pkg::ST_EXP_GREEN: state_q <= n64_video_pkg::ST_EXP_BLUE;
        default:                     state_q <= n64_video_pkg::ST_WAIT_SYNC;
      endcase
    end
  end

  always_ff @(posedge N64_CLK_i) begin
    if (!nVDSYNC_i) begin
      sync_q <= VD_i[n64_video_pkg::SYNC_W-1:0];
    end else if (state_q == n64_video_pkg::ST_EXP_RED) begin
      red_q <= VD_i;
    end else if (state_q == n64_video_pkg::ST_EXP_GREEN) begin
      green_q <= VD_i;
    end
  end

  // ==========================================================================
  // pixel hand-off
  // ==========================================================================

  always_ff @(posedge N64_CLK_i) begin
    if (!rst_n_i) begin
      pix_valid_o <= 1'b0;
      overflow_o  <= 1'b0;
    end else begin
      if (pixel_done) begin
        pix_valid_o <= 1'b1;
      end else if (pix_taken) begin
        pix_valid_o <= 1'b0;
      end
      // bus cannot stall, so an untaken pixel gets replaced
      if (pixel_done && pix_valid_o && !pix_ready_i) begin
        overflow_o <= 1'b1;
      end
    end
  end

  // blue comes straight from the bus
  always_ff @(posedge N64_CLK_i) begin
    if (pixel_done) begin
      pix_sync_o  <= sync_q;
      pix_red_o   <= red_q;
      pix_green_o <= green_q;
      pix_blue_o  <= VD_i;
    end
  end

  // red phase is only ever entered straight from a sync word
  a_red_after_sync : assert property (
    @(posedge N64_CLK_i) disable iff (!rst_n_i)
    (state_q == n64_video_pkg::ST_EXP_RED) |-> $past(!nVDSYNC_i)
  );

endmodule

`default_nettype wire

// ==== hdl/color_lane.sv ====
// colour lane with 7 to 8 bit widening, 16-bit colour reduction and dark gamma

`timescale 1ns/1ps
`default_nettype none

module color_lane (
  input  wire logic                       N64_CLK_i,
  input  wire logic                       rst_n_i,
  input  wire logic                       cfg_color_16bit_i,
  input  wire logic                       cfg_gamma_dark_i,
  input  wire logic                       in_valid_i,
  output logic                            in_ready_o,
  input  wire n64_video_pkg::color_in_t   in_color_i,
  input  wire n64_video_pkg::sync_word_t  in_tag_i,
  output logic                            out_valid_o,
  input  wire logic                       out_ready_i,
  output n64_video_pkg::color_out_t       out_color_o,
  output n64_video_pkg::sync_word_t       out_tag_o
);

  logic                      s1_valid_q;
  n64_video_pkg::color_out_t s1_color_q;
  n64_video_pkg::sync_word_t s1_tag_q;

  logic s1_ready;
  logic s2_ready;

  n64_video_pkg::color_in_t                masked;
  n64_video_pkg::color_out_t               widened;
  logic [2*n64_video_pkg::COLOR_OUT_W-1:0] square;
  n64_video_pkg::color_out_t               curved;

  // each register loads when empty or drained in the same cycle
  assign s2_ready   = !out_valid_o || out_ready_i;
  assign s1_ready   = !s1_valid_q || s2_ready;
  assign in_ready_o = s1_ready;

  // ==========================================================================
  // stage 1
  // ==========================================================================

  always_comb begin
    masked = in_color_i;
    if (cfg_color_16bit_i) begin
      masked[n64_video_pkg::LOW_BITS_16BIT-1:0] = '0;
    end
  end

  // msb repeated as new lsb so full scale maps to 8'hff
  assign widened = {masked, masked[n64_video_pkg::COLOR_IN_W-1]};

  // ==========================================================================
  // stage 2
  // ==========================================================================

  assign square = s1_color_q * s1_color_q;
  assign curved = cfg_gamma_dark_i ? square[2*n64_video_pkg::COLOR_OUT_W-1:n64_video_pkg::COLOR_OUT_W]
                                   : s1_color_q;

  always_ff @(posedge N64_CLK_i) begin
    if (!rst_n_i) begin
      s1_valid_q  <= 1'b0;
      out_valid_o <= 1'b0;
    end else begin
      if (s1_ready) begin
        s1_valid_q <= in_valid_i;
      end
      if (s2_ready) begin
        out_valid_o <= s1_valid_q;
      end
    end
  end

  always_ff @(posedge N64_CLK_i) begin
    if (s1_ready && in_valid_i) begin
      s1_color_q <= widened;
      s1_tag_q   <= in_tag_i;
    end
    if (s2_ready && s1_valid_q) begin
      out_color_o <= curved;
      out_tag_o   <= s1_tag_q;
    end
  end

  a_hold_when_stalled : assert property (
    @(posedge N64_CLK_i) disable iff (!rst_n_i)
    (out_valid_o && !out_ready_i) |=>
      (out_valid_o && $stable(out_color_o) && $stable(out_tag_o))
  );

endmodule

`default_nettype wire

// ==== hdl/pixel_out_stage.sv ====
// output stage that joins the colour lanes and decodes the N64 sync word

`timescale 1ns/1ps
`default_nettype none

module pixel_out_stage (
  input  wire logic                                    N64_CLK_i,
  input  wire logic                                    rst_n_i,
  input  wire logic [n64_video_pkg::NUM_CHANNELS-1:0]  lane_valid_i,
  output logic                                         lane_ready_o,
  input  wire n64_video_pkg::color_out_t               lane_red_i,
  input  wire n64_video_pkg::color_out_t               lane_green_i,
  input  wire n64_video_pkg::color_out_t               lane_blue_i,
  input  wire n64_video_pkg::sync_word_t               lane_sync_i,
  output logic                                         out_valid_o,
  input  wire logic                                    out_ready_i,
  output logic [n64_video_pkg::NUM_CHANNELS*n64_video_pkg::COLOR_OUT_W-1:0] VD_o,
  output logic                                         VSYNC_o,
  output logic                                         HSYNC_o,
  output logic                                         DE_o
);

  logic all_valid;
  logic load;

  assign all_valid    = &lane_valid_i;
  assign lane_ready_o = !out_valid_o || out_ready_i;
  assign load         = all_valid && lane_ready_o;

  always_ff @(posedge N64_CLK_i) begin
    if (!rst_n_i) begin
      out_valid_o <= 1'b0;
    end else if (lane_ready_o) begin
      out_valid_o <= all_valid;
    end
  end

  // ==========================================================================
  // pixel and sync registers
  // ==========================================================================

  always_ff @(posedge N64_CLK_i) begin
    if (load) begin
      // red in the top byte
      VD_o    <= {lane_red_i, lane_green_i, lane_blue_i};
      VSYNC_o <= !lane_sync_i[n64_video_pkg::SYNC_NVSYNC_BIT];
      HSYNC_o <= !lane_sync_i[n64_video_pkg::SYNC_NHSYNC_BIT];
      // active video outside both sync pulses
      DE_o    <= lane_sync_i[n64_video_pkg::SYNC_NVSYNC_BIT] &&
                 lane_sync_i[n64_video_pkg::SYNC_NHSYNC_BIT];
    end
  end

  // lanes share valid and ready, so they never drift apart
  a_lanes_lockstep : assert property (
    @(posedge N64_CLK_i) disable iff (!rst_n_i)
    (lane_valid_i == '0) || (&lane_valid_i)
  );

endmodule

`default_nettype wire

// ==== hdl/n64_video_ppu_top.sv ====
// n64 video front end top with demux, three colour lanes and the output stage

`timescale 1ns/1ps
`default_nettype none

module n64_video_ppu_top (
  input  wire logic                      N64_CLK_i,
  input  wire logic                      rst_n_i,
  input  wire logic                      nVDSYNC_i,
  input  wire n64_video_pkg::color_in_t  VD_i,
  input  wire logic                      cfg_color_16bit_i,
  input  wire logic                      cfg_gamma_dark_i,
  output logic                           out_valid_o,
  input  wire logic                      out_ready_i,
  output logic [n64_video_pkg::NUM_CHANNELS*n64_video_pkg::COLOR_OUT_W-1:0] VD_o,
  output logic                           VSYNC_o,
  output logic                           HSYNC_o,
  output logic                           DE_o,
  output logic                           overflow_o
);

  // demux to lanes
  logic                      pix_valid;
  n64_video_pkg::sync_word_t pix_sync;
  n64_video_pkg::color_in_t  pix_red;
  n64_video_pkg::color_in_t  pix_green;
  n64_video_pkg::color_in_t  pix_blue;

  n64_video_pkg::color_in_t  lane_in_color [n64_video_pkg::NUM_CHANNELS];
  n64_video_pkg::sync_word_t lane_in_tag   [n64_video_pkg::NUM_CHANNELS];
  logic [n64_video_pkg::NUM_CHANNELS-1:0] lane_in_ready;

  // lanes to output stage
  logic [n64_video_pkg::NUM_CHANNELS-1:0] lane_out_valid;
  n64_video_pkg::color_out_t lane_out_color [n64_video_pkg::NUM_CHANNELS];
  n64_video_pkg::sync_word_t lane_out_tag   [n64_video_pkg::NUM_CHANNELS];
  logic                      lane_ready;

  // ==========================================================================
  // demux
  // ==========================================================================

  n64_vdemux vdemux_i (
    .N64_CLK_i   (N64_CLK_i),
    .rst_n_i     (rst_n_i),
    .nVDSYNC_i   (nVDSYNC_i),
    .VD_i        (VD_i),
    .pix_valid_o (pix_valid),
    .pix_ready_i (lane_in_ready[0]),
    .pix_sync_o  (pix_sync),
    .pix_red_o   (pix_red),
    .pix_green_o (pix_green),
    .pix_blue_o  (pix_blue),
    .overflow_o  (overflow_o)
  );

  assign lane_in_color[0] = pix_red;
  assign lane_in_color[1] = pix_green;
  assign lane_in_color[2] = pix_blue;

  // ==========================================================================
  // colour lanes
  // ==========================================================================

  for (genvar i = 0; i < n64_video_pkg::NUM_CHANNELS; i++) begin : g_lane
    // only the red lane carries the sync word
    if (i == 0) begin : g_tag
      assign lane_in_tag[i] = pix_sync;
    end else begin : g_no_tag
      assign lane_in_tag[i] = '0;
    end

    color_lane lane_i (
      .N64_CLK_i         (N64_CLK_i),
      .rst_n_i           (rst_n_i),
      .cfg_color_16bit_i (cfg_color_16bit_i),
      .cfg_gamma_dark_i  (cfg_gamma_dark_i),
      .in_valid_i        (pix_valid),
      .in_ready_o        (lane_in_ready[i]),
      .in_color_i        (lane_in_color[i]),
      .in_tag_i          (lane_in_tag[i]),
      .out_valid_o       (lane_out_valid[i]),
      .out_ready_i       (lane_ready),
      .out_color_o       (lane_out_color[i]),
      .out_tag_o         (lane_out_tag[i])
    );
  end

  // ==========================================================================
  // output stage
  // ==========================================================================

  pixel_out_stage out_stage_i (
    .N64_CLK_i    (N64_CLK_i),
    .rst_n_i      (rst_n_i),
    .lane_valid_i (lane_out_valid),
    .lane_ready_o (lane_ready),
    .lane_red_i   (lane_out_color[0]),
    .lane_green_i (lane_out_color[1]),
    .lane_blue_i  (lane_out_color[2]),
    .lane_sync_i  (lane_out_tag[0]),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .VD_o         (VD_o),
    .VSYNC_o      (VSYNC_o),
    .HSYNC_o      (HSYNC_o),
    .DE_o         (DE_o)
  );

endmodule

`default_nettype wire

// ==== tb/tb_ppu_top.sv ====
// testbench for the n64 video front end with a reference queue and output assertions

`timescale 1ns/1ps
`default_nettype none

module tb_ppu_top;

  // expected entry is {rgb, vsync, hsync, de}
  localparam int EXP_W      = 27;
  localparam int WAIT_LIMIT = 400;

  logic                      clk = 1'b0;
  logic                      rst_n;
  logic                      nvdsync;
  n64_video_pkg::color_in_t  vd;
  logic                      cfg_16bit;
  logic                      cfg_dark;
  logic                      out_valid;
  logic                      out_ready;
  logic [23:0]               vd_out;
  logic                      vsync;
  logic                      hsync;
  logic                      de;
  logic                      overflow;

  logic [EXP_W-1:0] exp_q[$];
  logic [EXP_W-1:0] exp_head = '0;
  int               exp_cnt  = 0;
  logic [EXP_W-1:0] actual;
  string            test_name = "reset";
  logic [31:0]      stim_seed  = 32'h2a3c;
  logic [31:0]      ready_seed = 32'h2a3c;
  logic             bp_mode;
  logic             ready_level;
  logic             ovf_allowed;
  int               low_run = 0;

  assign actual = {vd_out, vsync, hsync, de};

  always #4 clk = ~clk;

  n64_video_ppu_top dut_i (
    .N64_CLK_i         (clk),
    .rst_n_i           (rst_n),
    .nVDSYNC_i         (nvdsync),
    .VD_i              (vd),
    .cfg_color_16bit_i (cfg_16bit),
    .cfg_gamma_dark_i  (cfg_dark),
    .out_valid_o       (out_valid),
    .out_ready_i       (out_ready),
    .VD_o              (vd_out),
    .VSYNC_o           (vsync),
    .HSYNC_o           (hsync),
    .DE_o              (de),
    .overflow_o        (overflow)
  );

  // ==========================================================================
  // reference model
  // ==========================================================================

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic n64_video_pkg::color_out_t lane_model(input n64_video_pkg::color_in_t s,
                                                           input logic m16, input logic dark);
    int v;
    int w;
    v = int'(s);
    if (m16) begin
      v = v - (v % 4);
    end
    // shift up one place with the old msb as the new lsb
    w = v * 2 + v / 64;
    if (dark) begin
      w = (w * w) / 256;
    end
    return n64_video_pkg::color_out_t'(w);
  endfunction

  function automatic logic [EXP_W-1:0] expected_pixel(input n64_video_pkg::sync_word_t s,
                                                      input n64_video_pkg::color_in_t red,
                                                      input n64_video_pkg::color_in_t green,
                                                      input n64_video_pkg::color_in_t blue);
    logic nv;
    logic nh;
    nv = s[n64_video_pkg::SYNC_NVSYNC_BIT];
    nh = s[n64_video_pkg::SYNC_NHSYNC_BIT];
    return {lane_model(red, cfg_16bit, cfg_dark), lane_model(green, cfg_16bit, cfg_dark),
            lane_model(blue, cfg_16bit, cfg_dark), !nv, !nh, nv && nh};
  endfunction

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "first error reached");
  endtask

  // ==========================================================================
  // scoreboard and checks
  // ==========================================================================

  always @(posedge clk) begin
    if (rst_n && out_valid && out_ready && exp_q.size() > 0) begin
      void'(exp_q.pop_front());
    end
  end

  // head of queue settles half a cycle before the next check
  always @(negedge clk) begin
    exp_cnt  <= exp_q.size();
    exp_head <= (exp_q.size() > 0) ? exp_q[0] : '0;
  end

  // random stall pattern with ready low for two cycles at most
  always @(posedge clk) begin
    if (bp_mode) begin
      ready_seed = lcg_step(ready_seed);
      if (low_run >= 2 || ready_seed[31]) begin
        out_ready <= 1'b1;
        low_run = 0;
      end else begin
        out_ready <= 1'b0;
        low_run = low_run + 1;
      end
    end else begin
      out_ready <= ready_level;
      low_run = 0;
    end
  end

  a_out_expected : assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && out_ready) |-> (exp_cnt != 0))
    else stop_run($sformatf("unexpected output pixel in %s", test_name));

  a_out_match : assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && out_ready && exp_cnt != 0) |-> (actual == exp_head))
    else stop_run($sformatf("Mismatch in %s: expected %h, actual %h",
                            test_name, $sampled(exp_head), $sampled(actual)));

  a_hold_stalled : assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(actual)))
    else stop_run($sformatf("output pixel changed while stalled in %s", test_name));

  a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n || ovf_allowed)
    !overflow)
    else stop_run($sformatf("overflow flag rose in %s", test_name));

  // ==========================================================================
  // stimulus
  // ==========================================================================

  task automatic drive_word(input logic sync_n, input n64_video_pkg::color_in_t word);
    @(posedge clk);
    nvdsync <= sync_n;
    vd      <= word;
  endtask

  task automatic send_pixel(input logic track);
    n64_video_pkg::sync_word_t s;
    n64_video_pkg::color_in_t  red;
    n64_video_pkg::color_in_t  green;
    n64_video_pkg::color_in_t  blue;
    stim_seed = lcg_step(stim_seed);
    s     = stim_seed[31:28];
    red   = stim_seed[27:21];
    green = stim_seed[20:14];
    blue  = stim_seed[13:7];
    // upper bus bits are don't care during a sync word
    drive_word(1'b0, {red[2:0], s});
    drive_word(1'b1, red);
    drive_word(1'b1, green);
    drive_word(1'b1, blue);
    if (track) begin
      exp_q.push_back(expected_pixel(s, red, green, blue));
    end
  endtask

  // sync and one or two colours that the next sync cuts short
  task automatic send_partial();
    stim_seed = lcg_step(stim_seed);
    drive_word(1'b0, stim_seed[30:24]);
    drive_word(1'b1, stim_seed[22:16]);
    if (stim_seed[31]) begin
      drive_word(1'b1, stim_seed[14:8]);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > WAIT_LIMIT) begin
        stop_run($sformatf("pipeline did not drain in %s", test_name));
      end
    end while (exp_cnt != 0 || out_valid);
  endtask

  initial begin
    int n;
    rst_n       = 1'b0;
    nvdsync     = 1'b1;
    vd          = '0;
    cfg_16bit   = 1'b0;
    cfg_dark    = 1'b0;
    out_ready   = 1'b0;
    bp_mode     = 1'b0;
    ready_level = 1'b1;
    ovf_allowed = 1'b0;
    wait_cycles(10);
    rst_n <= 1'b1;

    test_name = "linear";
    repeat (40) send_pixel(1'b1);
    wait_drain();

    test_name = "color_16bit";
    cfg_16bit <= 1'b1;
    repeat (40) send_pixel(1'b1);
    wait_drain();

    test_name = "gamma_dark";
    cfg_16bit <= 1'b0;
    cfg_dark  <= 1'b1;
    repeat (40) send_pixel(1'b1);
    wait_drain();

    test_name = "sync_restart";
    cfg_dark <= 1'b0;
    repeat (20) begin
      send_partial();
      send_pixel(1'b1);
    end
    wait_drain();

    test_name = "backpressure";
    bp_mode <= 1'b1;
    repeat (60) send_pixel(1'b1);
    wait_drain();

    // with the output stalled four pixels fill the pipeline
    test_name = "overflow";
    bp_mode     <= 1'b0;
    ready_level <= 1'b0;
    ovf_allowed <= 1'b1;
    wait_cycles(2);
    repeat (4) send_pixel(1'b0);
    wait_cycles(6);
    a_full_no_ovf : assert (!overflow)
      else stop_run("overflow flag rose with only four pixels in the pipeline");
    send_pixel(1'b0);
    n = 0;
    while (!overflow) begin
      @(posedge clk);
      n++;
      if (n > 10) begin
        stop_run("overflow flag did not rise after the fifth pixel");
      end
    end

    rst_n <= 1'b0;
    wait_cycles(10);
    rst_n       <= 1'b1;
    ovf_allowed <= 1'b0;
    wait_cycles(2);
    if (exp_q.size() == 0 && !overflow && !out_valid) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("Simulation failed");
      $fatal(1, "pixels left in the queue or output valid or overflow still set after reset");
    end
  end

endmodule

`default_nettype wire

// ==== tb.f ====
hdl/n64_video_pkg.sv
hdl/n64_vdemux.sv
hdl/color_lane.sv
hdl/pixel_out_stage.sv
hdl/n64_video_ppu_top.sv
tb/tb_ppu_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the N64 video front end testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=Vtb_ppu_top

verilator --binary --timing --assert -Wno-fatal \
  -f tb.f --top-module tb_ppu_top \
  --Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
  exit 0
else
  echo "pass message not found in $LOG"
  exit 1
fi
